// File: source/control_cmd_dispatch.sv
// ============================================================
// command dispatcher
// decodes opcodes, routes strobes, merges the write ports
// ============================================================
`timescale 1ns/1ps

module control_cmd_dispatch (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] data_in,
    input  logic       data_valid,
    input  logic       readrow_done,
    input  logic       fill_done,
    output logic       readrow_enable,
    output logic       fill_start,
    output logic [7:0] cmd_data,
    output logic       busy,
    output logic       cmd_done,
    output logic       bad_opcode,
    ram_port_if.memory row_src,
    ram_port_if.memory fill_src,
    ram_port_if.writer mem
);
    import display_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITE_ROW,
        S_FILL_START,
        S_FILL_WAIT
    } state_t;

    state_t      state;
    cmd_opcode_t opcode;
    logic        fill_sel;

    assign opcode = cmd_opcode_t'(data_in);

    // strobes reach the commands in the same cycle
    assign cmd_data = data_in;
    assign readrow_enable = data_valid && (state == S_WRITE_ROW);
    assign fill_start = data_valid && (state == S_FILL_START);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            busy <= 1'b0;
            cmd_done <= 1'b0;
            bad_opcode <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            bad_opcode <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (data_valid) begin
                        case (opcode)
                            CMD_WRITE_ROW: begin
                                busy <= 1'b1;
                                state <= S_WRITE_ROW;
                            end
                            CMD_FILL: begin
                                busy <= 1'b1;
                                state <= S_FILL_START;
                            end
                            default: bad_opcode <= 1'b1;
                        endcase
                    end
                end
                S_WRITE_ROW: begin
                    if (readrow_done) begin
                        cmd_done <= 1'b1;
                        busy <= 1'b0;
                        state <= S_IDLE;
                    end
                end
                S_FILL_START: begin
                    if (data_valid) begin
                        state <= S_FILL_WAIT;
                    end
                end
                default: begin
                    if (fill_done) begin
                        cmd_done <= 1'b1;
                        busy <= 1'b0;
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // ============================================================
    // write port merge
    // ============================================================

    assign fill_sel = (state == S_FILL_START) || (state == S_FILL_WAIT);

    assign mem.row = fill_sel ? fill_src.row : row_src.row;
    assign mem.column = fill_sel ? fill_src.column : row_src.column;
    assign mem.pixel = fill_sel ? fill_src.pixel : row_src.pixel;
    assign mem.data = fill_sel ? fill_src.data : row_src.data;
    assign mem.write_enable = fill_sel ? fill_src.write_enable : row_src.write_enable;
    // each command toggle yields exactly one edge here
    assign mem.access_start = row_src.access_start ^ fill_src.access_start;

    one_command_started: assert property (
        @(posedge clk) disable iff (reset) !(readrow_enable && fill_start)
    ) else $error("readrow_enable and fill_start high together");

endmodule

// File: source/control_cmd_fill.sv
// ============================================================
// FILL command
// writes one value to every frame buffer byte, one per clock
// ============================================================
`timescale 1ns/1ps

module control_cmd_fill #(
    parameter int PIXEL_WIDTH = 8,
    parameter int ROW_COUNT = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic [7:0] value,
    output logic       done,
    ram_port_if.writer ram
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DONE
    } state_t;

    state_t state;
    logic   load;
    logic   step;
    logic   addr_last;

    assign load = start && (state == S_IDLE);
    assign step = (state == S_RUN) && !addr_last;

    frame_addr_counter #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .ROW_COUNT(ROW_COUNT)
    ) u_addr (
        .clk(clk),
        .reset(reset),
        .load(load),
        .step(step),
        .walk_rows(1'b1),
        .start_row('0),
        .row(ram.row),
        .column(ram.column),
        .pixel(ram.pixel),
        .last(addr_last)
    );

    always_ff @(posedge clk) begin
        if (load) begin
            ram.data <= value;
        end
    end

    // the first toggle goes out with the load, then one per step
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            done <= 1'b0;
            ram.write_enable <= 1'b0;
            ram.access_start <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (load) begin
                        ram.write_enable <= 1'b1;
                        ram.access_start <= !ram.access_start;
                        state <= S_RUN;
                    end
                end
                S_RUN: begin
                    if (step) begin
                        ram.access_start <= !ram.access_start;
                    end else begin
                        ram.write_enable <= 1'b0;
                        done <= 1'b1;
                        state <= S_DONE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: source/control_cmd_readrow.sv
// ============================================================
// WRITE_ROW command
// captures a row number, then writes one row of streamed bytes
// ============================================================
`timescale 1ns/1ps

module control_cmd_readrow #(
    parameter int PIXEL_WIDTH = 8,
    parameter int ROW_COUNT = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       enable,
    input  logic [7:0] data_in,
    output logic       done,
    ram_port_if.writer ram
);
    import display_pkg::*;

    typedef enum logic [1:0] {
        S_ROW_CAPTURE,
        S_PRIME_WRITE,
        S_ROW_CONTENT,
        S_DONE
    } state_t;

    state_t    state;
    row_addr_t row_sel;
    logic      load;
    logic      step;

    assign load = enable && (state == S_PRIME_WRITE);
    assign step = enable && (state == S_ROW_CONTENT);

    frame_addr_counter #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .ROW_COUNT(ROW_COUNT)
    ) u_addr (
        .clk(clk),
        .reset(reset),
        .load(load),
        .step(step),
        .walk_rows(1'b0),
        .start_row(row_sel),
        .row(ram.row),
        .column(ram.column),
        .pixel(ram.pixel),
        .last()
    );

    always_ff @(posedge clk) begin
        if (load || step) begin
            ram.data <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_ROW_CAPTURE;
            row_sel <= '0;
            done <= 1'b0;
            ram.write_enable <= 1'b0;
            ram.access_start <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_ROW_CAPTURE: begin
                    if (enable) begin
                        // rows past the panel fold back onto it
                        row_sel <= row_addr_t'(data_in % ROW_COUNT);
                        state <= S_PRIME_WRITE;
                    end
                end
                S_PRIME_WRITE: begin
                    if (enable) begin
                        ram.write_enable <= 1'b1;
                        ram.access_start <= !ram.access_start;
                        state <= S_ROW_CONTENT;
                    end
                end
                S_ROW_CONTENT: begin
                    // the counter is at the last address once this byte lands
                    if (enable) begin
                        ram.access_start <= !ram.access_start;
                        if (ram.column == '0 && ram.pixel == pixel_addr_t'(1)) begin
                            done <= 1'b1;
                            state <= S_DONE;
                        end
                    end
                end
                default: begin
                    ram.write_enable <= 1'b0;
                    state <= S_ROW_CAPTURE;
                end
            endcase
        end
    end

    // bytes arriving while the command finishes produce no write
    done_drops_bytes: assert property (
        @(posedge clk) disable iff (reset) state == S_DONE |=> $stable(ram.access_start)
    ) else $error("write issued from the done state");

    capture_no_write: assert property (
        @(posedge clk) disable iff (reset) state == S_ROW_CAPTURE |-> !ram.write_enable
    ) else $error("write_enable high during row capture");

endmodule

// File: source/display_ctrl_top.sv
// ============================================================
// LED matrix frame buffer command controller
// ============================================================
`timescale 1ns/1ps

module display_ctrl_top #(
    parameter int PIXEL_WIDTH = 8,
    parameter int ROW_COUNT = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] data_in,
    input  logic       data_valid,
    output logic       busy,
    output logic       cmd_done,
    output logic       bad_opcode,
    input  logic [$bits(display_pkg::row_addr_t)-1:0]   read_row,
    input  logic [$bits(display_pkg::col_addr_t)-1:0]   read_column,
    input  logic [$bits(display_pkg::pixel_addr_t)-1:0] read_pixel,
    output logic [7:0] read_data
);
    logic [7:0] cmd_data;
    logic       readrow_enable;
    logic       readrow_done;
    logic       fill_start;
    logic       fill_done;

    ram_port_if readrow_port ();
    ram_port_if fill_port ();
    ram_port_if mem_port ();

    control_cmd_dispatch u_dispatch (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .data_valid(data_valid),
        .readrow_done(readrow_done),
        .fill_done(fill_done),
        .readrow_enable(readrow_enable),
        .fill_start(fill_start),
        .cmd_data(cmd_data),
        .busy(busy),
        .cmd_done(cmd_done),
        .bad_opcode(bad_opcode),
        .row_src(readrow_port.memory),
        .fill_src(fill_port.memory),
        .mem(mem_port.writer)
    );

    control_cmd_readrow #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .ROW_COUNT(ROW_COUNT)
    ) u_readrow (
        .clk(clk),
        .reset(reset),
        .enable(readrow_enable),
        .data_in(cmd_data),
        .done(readrow_done),
        .ram(readrow_port.writer)
    );

    control_cmd_fill #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .ROW_COUNT(ROW_COUNT)
    ) u_fill (
        .clk(clk),
        .reset(reset),
        .start(fill_start),
        .value(cmd_data),
        .done(fill_done),
        .ram(fill_port.writer)
    );

    frame_buffer #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .ROW_COUNT(ROW_COUNT)
    ) u_frame (
        .clk(clk),
        .reset(reset),
        .wr(mem_port.memory),
        .read_row(read_row),
        .read_column(read_column),
        .read_pixel(read_pixel),
        .read_data(read_data)
    );

endmodule

// File: source/display_pkg.sv
// ============================================================
// display controller shared definitions
// address types, size limits, colour depth and opcodes
// ============================================================
package display_pkg;

    // upper limits that size the address types
    localparam int MAX_ROWS = 32;
    localparam int MAX_COLUMNS = 64;

    // each pixel holds BYTES_PER_PIXEL colour bytes numbered from 0
    localparam int BYTES_PER_PIXEL = 3;

    typedef logic [$clog2(MAX_ROWS)-1:0] row_addr_t;
    typedef logic [$clog2(MAX_COLUMNS)-1:0] col_addr_t;
    typedef logic [$clog2(BYTES_PER_PIXEL)-1:0] pixel_addr_t;

    // first byte of every command on the host stream
    typedef enum logic [7:0] {
        CMD_WRITE_ROW = 8'h01,
        CMD_FILL      = 8'h02
    } cmd_opcode_t;

endpackage

// File: source/frame_addr_counter.sv
// ============================================================
// frame address down-counter
// walks colour byte, column and optionally row down to zero
// ============================================================
`timescale 1ns/1ps

module frame_addr_counter #(
    parameter int PIXEL_WIDTH = 8,
    parameter int ROW_COUNT = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load,
    input  logic                   step,
    input  logic                   walk_rows,
    input  display_pkg::row_addr_t start_row,
    output display_pkg::row_addr_t   row,
    output display_pkg::col_addr_t   column,
    output display_pkg::pixel_addr_t pixel,
    output logic                   last
);
    import display_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            row <= '0;
            column <= '0;
            pixel <= '0;
        end else if (load) begin
            row <= walk_rows ? row_addr_t'(ROW_COUNT - 1) : start_row;
            column <= col_addr_t'(PIXEL_WIDTH - 1);
            pixel <= pixel_addr_t'(BYTES_PER_PIXEL - 1);
        end else if (step) begin
            if (pixel != '0) begin
                pixel <= pixel - 1'b1;
            end else begin
                pixel <= pixel_addr_t'(BYTES_PER_PIXEL - 1);
                if (column != '0) begin
                    column <= column - 1'b1;
                end else begin
                    column <= col_addr_t'(PIXEL_WIDTH - 1);
                    if (walk_rows) begin
                        row <= (row != '0) ? row - 1'b1 : row_addr_t'(ROW_COUNT - 1);
                    end
                end
            end
        end
    end

    // the row only counts toward the end when rows are walked
    assign last = (column == '0) && (pixel == '0) && (!walk_rows || row == '0);

    column_in_range: assert property (
        @(posedge clk) disable iff (reset) column <= PIXEL_WIDTH - 1
    ) else $error("column %0d beyond row width", column);

endmodule

// File: source/frame_buffer.sv
// ============================================================
// frame buffer memory
// toggle-triggered write port and registered read port
// ============================================================
`timescale 1ns/1ps

module frame_buffer #(
    parameter int PIXEL_WIDTH = 8,
    parameter int ROW_COUNT = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    ram_port_if.memory               wr,
    input  display_pkg::row_addr_t   read_row,
    input  display_pkg::col_addr_t   read_column,
    input  display_pkg::pixel_addr_t read_pixel,
    output logic [7:0]               read_data
);
    import display_pkg::*;

    localparam int DEPTH = ROW_COUNT * PIXEL_WIDTH * BYTES_PER_PIXEL;

    logic [7:0] mem [DEPTH];
    logic       last_start;
    logic       write_now;
    int         wr_index;
    int         rd_index;

    always_comb begin
        wr_index = (int'(wr.row) * PIXEL_WIDTH + int'(wr.column)) * BYTES_PER_PIXEL
                   + int'(wr.pixel);
        rd_index = (int'(read_row) * PIXEL_WIDTH + int'(read_column)) * BYTES_PER_PIXEL
                   + int'(read_pixel);
    end

    assign write_now = wr.write_enable && (wr.access_start != last_start);

    always_ff @(posedge clk) begin
        if (reset) begin
            last_start <= 1'b0;
            read_data <= 8'd0;
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= 8'd0;
            end
        end else begin
            last_start <= wr.access_start;
            if (write_now) begin
                mem[wr_index] <= wr.data;
            end
            read_data <= (rd_index < DEPTH) ? mem[rd_index] : 8'd0;
        end
    end

    write_in_range: assert property (
        @(posedge clk) disable iff (reset)
        write_now |-> (wr.row < ROW_COUNT && wr.column < PIXEL_WIDTH
                       && wr.pixel < BYTES_PER_PIXEL)
    ) else $error("write outside the frame at row %0d column %0d", wr.row, wr.column);

endmodule

// File: source/ram_port_if.sv
// ============================================================
// frame buffer write port, toggle triggered
// ============================================================
`timescale 1ns/1ps

interface ram_port_if;
    import display_pkg::*;

    row_addr_t   row;
    col_addr_t   column;
    pixel_addr_t pixel;
    logic [7:0]  data;
    logic        write_enable;
    // every change of this line is one write while write_enable is high
    logic        access_start;

    modport writer (
        output row, column, pixel, data, write_enable, access_start
    );

    modport memory (
        input row, column, pixel, data, write_enable, access_start
    );

endinterface

// File: sources.f
source/display_pkg.sv
source/ram_port_if.sv
source/frame_addr_counter.sv
source/control_cmd_readrow.sv
source/control_cmd_fill.sv
source/control_cmd_dispatch.sv
source/frame_buffer.sv
source/display_ctrl_top.sv
test/tb_display_ctrl.sv

// File: test/tb_display_ctrl.sv
// ============================================================
// testbench for the LED matrix frame buffer controller
// ============================================================
`timescale 1ns/1ps

module tb_display_ctrl;

    localparam int PIXEL_WIDTH = 8;
    localparam int ROW_COUNT = 4;
    localparam int BYTES_PER_PIXEL = 3;
    localparam int ROW_BYTES = PIXEL_WIDTH * BYTES_PER_PIXEL;
    localparam int FRAME_BYTES = ROW_COUNT * ROW_BYTES;
    localparam logic [7:0] OP_WRITE_ROW = 8'h01;
    localparam logic [7:0] OP_FILL = 8'h02;
    localparam logic [7:0] OP_UNKNOWN = 8'h7f;
    localparam int PLAIN = 0;
    localparam int VALID_OP = 1;
    localparam int BAD_OP = 2;
    localparam int LAST_DATA = 3;
    localparam int WAIT_LIMIT = 400;

    logic       clk;
    logic       reset;
    logic [7:0] data_in;
    logic       data_valid;
    logic       busy;
    logic       cmd_done;
    logic       bad_opcode;
    logic [4:0] read_row;
    logic [5:0] read_column;
    logic [1:0] read_pixel;
    logic [7:0] read_data;

    // these flags arm the checks and change together with the stimulus
    logic       op_valid;
    logic       op_invalid;
    logic       last_strobe;
    logic       idle_check;
    logic       rd_check;
    logic [7:0] rd_expect;
    int         rd_index;

    logic [7:0]  ref_mem [FRAME_BYTES];
    int unsigned rng_state = 83;
    int          error_count = 0;
    int          errors_at_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    display_ctrl_top dut (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .data_valid(data_valid),
        .busy(busy),
        .cmd_done(cmd_done),
        .bad_opcode(bad_opcode),
        .read_row(read_row),
        .read_column(read_column),
        .read_pixel(read_pixel),
        .read_data(read_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ============================================================
    // checks
    // ============================================================

    read_matches: assert property (
        @(posedge clk) disable iff (reset) rd_check |-> read_data == rd_expect
    ) else begin
        error_count++;
        $display("** Error: read_data at byte %0d expected 0x%02h got 0x%02h",
                 rd_index, rd_expect, $sampled(read_data));
    end

    reset_state_quiet: assert property (
        @(posedge clk) disable iff (reset) idle_check |-> !busy && !cmd_done && !bad_opcode
    ) else begin
        error_count++;
        $display("** Error: busy 0x%0h cmd_done 0x%0h bad_opcode 0x%0h, expected 0x0 each",
                 $sampled(busy), $sampled(cmd_done), $sampled(bad_opcode));
    end

    busy_after_opcode: assert property (
        @(posedge clk) disable iff (reset) op_valid |=> busy
    ) else begin
        error_count++;
        $display("** Error: busy expected 0x1 got 0x%0h", $sampled(busy));
    end

    bad_opcode_pulse: assert property (
        @(posedge clk) disable iff (reset) op_invalid |=> bad_opcode && !busy
    ) else begin
        error_count++;
        $display("** Error: bad_opcode expected 0x1 got 0x%0h, busy expected 0x0 got 0x%0h",
                 $sampled(bad_opcode), $sampled(busy));
    end

    bad_opcode_only_when_sent: assert property (
        @(posedge clk) disable iff (reset) bad_opcode |-> $past(op_invalid)
    ) else begin
        error_count++;
        $display("bad_opcode was raised without an unknown opcode before it");
    end

    cmd_done_single: assert property (
        @(posedge clk) disable iff (reset) cmd_done |=> !cmd_done
    ) else begin
        error_count++;
        $display("cmd_done stayed high for more than one cycle");
    end

    busy_falls_with_done: assert property (
        @(posedge clk) disable iff (reset) $fell(busy) |-> cmd_done
    ) else begin
        error_count++;
        $display("busy fell without a cmd_done pulse");
    end

    cmd_done_clears_busy: assert property (
        @(posedge clk) disable iff (reset) cmd_done |-> !busy
    ) else begin
        error_count++;
        $display("** Error: busy expected 0x0 with cmd_done, got 0x%0h", $sampled(busy));
    end

    done_two_after_last: assert property (
        @(posedge clk) disable iff (reset) last_strobe |=> !cmd_done ##1 cmd_done
    ) else begin
        error_count++;
        $display("cmd_done did not come exactly 2 cycles after the last data strobe");
    end

    // ============================================================
    // stimulus helpers
    // ============================================================

    function automatic logic [7:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[23:16];
    endfunction

    function automatic int frame_index(input int row, input int column, input int pixel);
        return (row * PIXEL_WIDTH + column) * BYTES_PER_PIXEL + pixel;
    endfunction

    // the task starts on a falling edge and returns on the next one
    task automatic send_byte(input logic [7:0] value, input int kind);
        data_in = value;
        data_valid = 1'b1;
        op_valid = (kind == VALID_OP);
        op_invalid = (kind == BAD_OP);
        last_strobe = (kind == LAST_DATA);
        @(negedge clk);
        data_valid = 1'b0;
        op_valid = 1'b0;
        op_invalid = 1'b0;
        last_strobe = 1'b0;
    endtask

    task automatic send_fill(input logic [7:0] value);
        send_byte(OP_FILL, VALID_OP);
        send_byte(value, PLAIN);
        for (int i = 0; i < FRAME_BYTES; i++) begin
            ref_mem[i] = value;
        end
    endtask

    // the first data byte lands at the top column and colour byte
    task automatic send_write_row(input logic [7:0] row_byte);
        int         target;
        int         column;
        int         pixel;
        logic [7:0] value;
        target = row_byte % ROW_COUNT;
        send_byte(OP_WRITE_ROW, VALID_OP);
        send_byte(row_byte, PLAIN);
        for (int k = 0; k < ROW_BYTES; k++) begin
            value = next_random();
            column = PIXEL_WIDTH - 1 - k / BYTES_PER_PIXEL;
            pixel = BYTES_PER_PIXEL - 1 - k % BYTES_PER_PIXEL;
            ref_mem[frame_index(target, column, pixel)] = value;
            send_byte(value, (k == ROW_BYTES - 1) ? LAST_DATA : PLAIN);
        end
    endtask

    task automatic wait_idle(input string what);
        int cycles;
        cycles = 0;
        while (busy && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            $display("timeout: busy still high %0d cycles into the %s command", cycles, what);
            $display("Done: errors found");
            $finish;
        end else begin
            @(negedge clk);
        end
    endtask

    // reads are pipelined so each check trails its address by one cycle
    task automatic check_memory();
        for (int i = 0; i <= FRAME_BYTES; i++) begin
            if (i < FRAME_BYTES) begin
                read_row = 5'(i / ROW_BYTES);
                read_column = 6'((i / BYTES_PER_PIXEL) % PIXEL_WIDTH);
                read_pixel = 2'(i % BYTES_PER_PIXEL);
            end
            if (i > 0) begin
                rd_check = 1'b1;
                rd_index = i - 1;
                rd_expect = ref_mem[i - 1];
            end
            @(negedge clk);
        end
        rd_check = 1'b0;
    endtask

    task automatic end_test(input string name);
        @(negedge clk);
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    // ============================================================
    // test sequence
    // ============================================================

    initial begin
        reset = 1'b1;
        data_in = 8'h00;
        data_valid = 1'b0;
        read_row = '0;
        read_column = '0;
        read_pixel = '0;
        op_valid = 1'b0;
        op_invalid = 1'b0;
        last_strobe = 1'b0;
        idle_check = 1'b0;
        rd_check = 1'b0;
        rd_expect = 8'h00;
        rd_index = 0;
        for (int i = 0; i < FRAME_BYTES; i++) begin
            ref_mem[i] = 8'h00;
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;

        idle_check = 1'b1;
        check_memory();
        idle_check = 1'b0;
        end_test("reset state");

        send_fill(next_random());
        wait_idle("fill");
        check_memory();
        end_test("fill");

        send_write_row(8'(next_random() % ROW_COUNT));
        wait_idle("write row");
        check_memory();
        end_test("write row");

        send_byte(OP_UNKNOWN, BAD_OP);
        wait_idle("unknown");
        check_memory();
        send_write_row(8'(next_random() % ROW_COUNT));
        wait_idle("write row");
        check_memory();
        end_test("unknown opcode");

        // these land while the fill is still walking the frame
        send_fill(next_random());
        for (int i = 0; i < 12; i++) begin
            send_byte(next_random(), PLAIN);
        end
        wait_idle("fill");
        check_memory();
        send_write_row(8'(next_random() % ROW_COUNT));
        wait_idle("write row");
        check_memory();
        end_test("strobes during fill");

        send_write_row(8'(ROW_COUNT + 1));
        wait_idle("write row");
        check_memory();
        end_test("row number wrap");

        $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
